//--- hw/lsu_iq_pkg.sv
package lsu_iq_pkg;

    localparam int iq_depth   = 8;
    localparam int iq_idx_w   = 3;
    localparam int iq_cnt_w   = 4;  // tail runs 0..8
    localparam int wake_ports = 4;
    localparam int preg_w     = 6;
    localparam int rob_w      = 5;

    typedef enum logic [2:0] {
        LB  = 3'h0,
        LH  = 3'h1,
        LW  = 3'h2,
        LBU = 3'h3,
        LHU = 3'h4,
        SB  = 3'h5,
        SH  = 3'h6,
        SW  = 3'h7
    } lsu_op_e;

    // one load/store micro-op as it sits in the queue
    typedef struct packed {
        lsu_op_e           op;
        logic [rob_w-1:0]  rob;
        logic [preg_w-1:0] dst;
        logic              dst_we;
        logic [preg_w-1:0] src1;      // base address
        logic              src1_rdy;
        logic [preg_w-1:0] src2;      // store data
        logic              src2_rdy;  // set by dispatch for loads
        logic [11:0]       imm;
    } lsu_uop_t;

    function automatic logic is_store(lsu_op_e op);
        logic st;
        st = (op == SB) || (op == SH) || (op == SW);
        return st;
    endfunction

endpackage

//--- hw/lsu_iq_entry.sv
`timescale 1ns/1ps

module lsu_iq_entry (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_en,
    input  logic                                enq_sel,    // 0 takes port 0
    input  logic                                shift_en,
    input  logic                                shift_two,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_0,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_1,
    input  lsu_iq_pkg::lsu_uop_t                up_one,
    input  lsu_iq_pkg::lsu_uop_t                up_two,
    input  logic [lsu_iq_pkg::wake_ports-1:0]   wake_en,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_0,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_1,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_2,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_3,
    output lsu_iq_pkg::lsu_uop_t                uop,
    output logic                                rdy,
    output logic                                store
);

    lsu_iq_pkg::lsu_uop_t          nxt_uop;
    lsu_iq_pkg::lsu_uop_t          woke_uop;
    logic [lsu_iq_pkg::preg_w-1:0] wake_tag [lsu_iq_pkg::wake_ports];
    logic                          src1_hit;
    logic                          src2_hit;

    assign wake_tag[0] = wake_tag_0;
    assign wake_tag[1] = wake_tag_1;
    assign wake_tag[2] = wake_tag_2;
    assign wake_tag[3] = wake_tag_3;

    // enqueue beats shift, shift beats hold
    always_comb begin
        if (enq_en) begin
            nxt_uop = enq_sel ? enq_uop_1 : enq_uop_0;
        end else if (shift_en) begin
            nxt_uop = shift_two ? up_two : up_one;
        end else begin
            nxt_uop = uop;
        end
    end

    // wakeup on whatever lands here, so a same-cycle broadcast still counts
    always_comb begin
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        for (int p = 0; p < lsu_iq_pkg::wake_ports; p++) begin
            if (wake_en[p] && (wake_tag[p] == nxt_uop.src1)) begin
                src1_hit = 1'b1;
            end
            if (wake_en[p] && (wake_tag[p] == nxt_uop.src2)) begin
                src2_hit = 1'b1;
            end
        end
        woke_uop          = nxt_uop;
        woke_uop.src1_rdy = nxt_uop.src1_rdy | src1_hit;
        woke_uop.src2_rdy = nxt_uop.src2_rdy | src2_hit;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            uop <= '0;
        end else begin
            uop <= woke_uop;
        end
    end

    assign rdy   = uop.src1_rdy & uop.src2_rdy;
    assign store = lsu_iq_pkg::is_store(uop.op);

endmodule

//--- hw/lsu_issue_queue.sv
`timescale 1ns/1ps

module lsu_issue_queue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_req_0,
    input  logic                                enq_req_1,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_0,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_1,
    input  logic [lsu_iq_pkg::wake_ports-1:0]   wake_en,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_0,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_1,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_2,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_3,
    input  logic                                lsu_busy,
    input  logic [lsu_iq_pkg::iq_idx_w-1:0]     sel0,
    input  logic                                sel0_valid,
    input  logic [lsu_iq_pkg::iq_idx_w-1:0]     sel1,
    input  logic                                sel1_valid,
    output logic                                ready,
    output lsu_iq_pkg::lsu_uop_t                deq_uop_0,
    output lsu_iq_pkg::lsu_uop_t                deq_uop_1,
    output logic [lsu_iq_pkg::iq_depth-1:0]     valid_vec,
    output logic [lsu_iq_pkg::iq_depth-1:0]     ready_vec,
    output logic [lsu_iq_pkg::iq_depth-1:0]     store_vec
);

    logic [lsu_iq_pkg::iq_cnt_w-1:0] tail;
    logic [lsu_iq_pkg::iq_cnt_w-1:0] base;     // tail after dequeues
    logic [lsu_iq_pkg::iq_cnt_w-1:0] n_enq;
    logic [lsu_iq_pkg::iq_cnt_w-1:0] n_deq;
    logic                            acc_0;
    logic                            acc_1;
    logic [lsu_iq_pkg::iq_depth-1:0] enq_en;
    logic [lsu_iq_pkg::iq_depth-1:0] enq_sel;
    logic [lsu_iq_pkg::iq_depth-1:0] shift_en;
    logic [lsu_iq_pkg::iq_depth-1:0] shift_two;
    logic [lsu_iq_pkg::iq_depth-1:0] raw_rdy;
    lsu_iq_pkg::lsu_uop_t            slot_uop [lsu_iq_pkg::iq_depth+2];

    // stall one slot early, two may arrive at once
    assign ready = (int'(tail) < lsu_iq_pkg::iq_depth - 1);

    assign acc_0 = ready & enq_req_0;
    assign acc_1 = ready & enq_req_1;

    assign n_enq = {{(lsu_iq_pkg::iq_cnt_w-1){1'b0}}, acc_0}
                 + {{(lsu_iq_pkg::iq_cnt_w-1){1'b0}}, acc_1};
    assign n_deq = {{(lsu_iq_pkg::iq_cnt_w-1){1'b0}}, sel0_valid}
                 + {{(lsu_iq_pkg::iq_cnt_w-1){1'b0}}, sel1_valid};
    assign base  = tail - n_deq;

    always_comb begin
        for (int i = 0; i < lsu_iq_pkg::iq_depth; i++) begin
            // new uops go right above the shifted survivors
            enq_en[i]    = (acc_0 && (int'(base) == i))
                        || (acc_1 && (int'(base) + int'(acc_0) == i));
            enq_sel[i]   = !(acc_0 && (int'(base) == i));
            // one hole below -> pull from i+1, two holes -> from i+2
            shift_en[i]  = sel0_valid && (i >= int'(sel0));
            shift_two[i] = sel1_valid && (i + 1 >= int'(sel1));
            valid_vec[i] = (i < int'(tail));
        end
    end

    // arbiter only sees issuable entries
    assign ready_vec = raw_rdy & valid_vec & {lsu_iq_pkg::iq_depth{~lsu_busy}};

    assign slot_uop[lsu_iq_pkg::iq_depth]   = '0;
    assign slot_uop[lsu_iq_pkg::iq_depth+1] = '0;

    for (genvar g = 0; g < lsu_iq_pkg::iq_depth; g++) begin : g_slot
        lsu_iq_entry u_entry (
            .clk        (clk),
            .rst        (rst),
            .flush      (flush),
            .enq_en     (enq_en[g]),
            .enq_sel    (enq_sel[g]),
            .shift_en   (shift_en[g]),
            .shift_two  (shift_two[g]),
            .enq_uop_0  (enq_uop_0),
            .enq_uop_1  (enq_uop_1),
            .up_one     (slot_uop[g+1]),
            .up_two     (slot_uop[g+2]),
            .wake_en    (wake_en),
            .wake_tag_0 (wake_tag_0),
            .wake_tag_1 (wake_tag_1),
            .wake_tag_2 (wake_tag_2),
            .wake_tag_3 (wake_tag_3),
            .uop        (slot_uop[g]),
            .rdy        (raw_rdy[g]),
            .store      (store_vec[g])
        );
    end

    assign deq_uop_0 = slot_uop[sel0];
    assign deq_uop_1 = slot_uop[sel1];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= base + n_enq;
        end
    end

endmodule

//--- hw/lsu_issue_arbiter.sv
`timescale 1ns/1ps

module lsu_issue_arbiter (
    input  logic [lsu_iq_pkg::iq_depth-1:0]  req_vec,
    input  logic [lsu_iq_pkg::iq_depth-1:0]  store_vec,
    output logic [lsu_iq_pkg::iq_idx_w-1:0]  sel0,
    output logic                             sel0_valid,
    output logic [lsu_iq_pkg::iq_idx_w-1:0]  sel1,
    output logic                             sel1_valid
);

    logic [lsu_iq_pkg::iq_depth-1:0] above;
    logic [lsu_iq_pkg::iq_depth-1:0] cand;
    logic                            sel0_store;

    // lowest index is oldest, scan down so the last hit wins
    always_comb begin
        sel0       = '0;
        sel0_valid = 1'b0;
        for (int i = lsu_iq_pkg::iq_depth - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                sel0       = i[lsu_iq_pkg::iq_idx_w-1:0];
                sel0_valid = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lsu_iq_pkg::iq_depth; i++) begin
            above[i] = (i > int'(sel0));
        end
    end

    assign sel0_store = sel0_valid & store_vec[sel0];

    // single store port
    assign cand = req_vec & above & ~(store_vec & {lsu_iq_pkg::iq_depth{sel0_store}});

    always_comb begin
        sel1       = '0;
        sel1_valid = 1'b0;
        for (int i = lsu_iq_pkg::iq_depth - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel1       = i[lsu_iq_pkg::iq_idx_w-1:0];
                sel1_valid = 1'b1;
            end
        end
    end

endmodule

//--- hw/lsu_issue_unit.sv
`timescale 1ns/1ps

module lsu_issue_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                enq_req_0,
    input  logic                                enq_req_1,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_0,
    input  lsu_iq_pkg::lsu_uop_t                enq_uop_1,
    input  logic [lsu_iq_pkg::wake_ports-1:0]   wake_en,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_0,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_1,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_2,
    input  logic [lsu_iq_pkg::preg_w-1:0]       wake_tag_3,
    input  logic                                lsu_busy,
    output logic                                ready,
    output logic                                issue_en_0,
    output logic                                issue_en_1,
    output lsu_iq_pkg::lsu_uop_t                issue_uop_0,
    output lsu_iq_pkg::lsu_uop_t                issue_uop_1
);

    logic [lsu_iq_pkg::iq_depth-1:0] ready_vec;   // already masked by busy
    logic [lsu_iq_pkg::iq_depth-1:0] store_vec;
    logic [lsu_iq_pkg::iq_idx_w-1:0] sel0;
    logic [lsu_iq_pkg::iq_idx_w-1:0] sel1;

    lsu_issue_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .enq_req_0  (enq_req_0),
        .enq_req_1  (enq_req_1),
        .enq_uop_0  (enq_uop_0),
        .enq_uop_1  (enq_uop_1),
        .wake_en    (wake_en),
        .wake_tag_0 (wake_tag_0),
        .wake_tag_1 (wake_tag_1),
        .wake_tag_2 (wake_tag_2),
        .wake_tag_3 (wake_tag_3),
        .lsu_busy   (lsu_busy),
        .sel0       (sel0),
        .sel0_valid (issue_en_0),  // a grant is an issue
        .sel1       (sel1),
        .sel1_valid (issue_en_1),
        .ready      (ready),
        .deq_uop_0  (issue_uop_0),
        .deq_uop_1  (issue_uop_1),
        .valid_vec  (),
        .ready_vec  (ready_vec),
        .store_vec  (store_vec)
    );

    lsu_issue_arbiter u_arbiter (
        .req_vec    (ready_vec),
        .store_vec  (store_vec),
        .sel0       (sel0),
        .sel0_valid (issue_en_0),
        .sel1       (sel1),
        .sel1_valid (issue_en_1)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

endmodule

//--- testbench/tb_lsu_issue_unit.sv
`timescale 1ns/1ps

module tb_lsu_issue_unit;

    logic                              clk;
    logic                              rst;
    logic                              flush;
    logic                              enq_req_0;
    logic                              enq_req_1;
    lsu_iq_pkg::lsu_uop_t              enq_uop_0;
    lsu_iq_pkg::lsu_uop_t              enq_uop_1;
    logic [lsu_iq_pkg::wake_ports-1:0] wake_en;
    logic [lsu_iq_pkg::preg_w-1:0]     wake_tag_0;
    logic [lsu_iq_pkg::preg_w-1:0]     wake_tag_1;
    logic [lsu_iq_pkg::preg_w-1:0]     wake_tag_2;
    logic [lsu_iq_pkg::preg_w-1:0]     wake_tag_3;
    logic                              lsu_busy;
    logic                              ready;
    logic                              issue_en_0;
    logic                              issue_en_1;
    lsu_iq_pkg::lsu_uop_t              issue_uop_0;
    lsu_iq_pkg::lsu_uop_t              issue_uop_1;

    logic [7:0]           vec_mem [0:1791];  // 28 columns per cycle, up to 64 cycles
    logic [7:0]           row [28];
    lsu_iq_pkg::lsu_uop_t sent [32];         // payloads as dispatched, by rob
    int                   n_vec = 0;
    int                   cycle_cnt = 0;
    int                   cycle_limit = 0;
    int                   bit_errs = 0;
    int                   op_errs = 0;

    tb_clock_gen u_clk (.clk(clk));

    lsu_issue_unit u_dut (
        .clk(clk), .rst(rst), .flush(flush),
        .enq_req_0(enq_req_0), .enq_req_1(enq_req_1),
        .enq_uop_0(enq_uop_0), .enq_uop_1(enq_uop_1),
        .wake_en(wake_en), .wake_tag_0(wake_tag_0), .wake_tag_1(wake_tag_1),
        .wake_tag_2(wake_tag_2), .wake_tag_3(wake_tag_3), .lsu_busy(lsu_busy),
        .ready(ready), .issue_en_0(issue_en_0), .issue_en_1(issue_en_1),
        .issue_uop_0(issue_uop_0), .issue_uop_1(issue_uop_1)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic lsu_iq_pkg::lsu_uop_t make_uop(input logic [7:0] op, input logic [7:0] rob,
            input logic [7:0] src1, input logic [7:0] rdy1,
            input logic [7:0] src2, input logic [7:0] rdy2);
        lsu_iq_pkg::lsu_uop_t u;
        u.op       = lsu_iq_pkg::lsu_op_e'(op[2:0]);
        u.rob      = rob[4:0];
        u.dst      = {1'b1, rob[4:0]};
        u.dst_we   = (u.op < lsu_iq_pkg::SB);  // loads write back
        u.src1     = src1[5:0];
        u.src1_rdy = rdy1[0];
        u.src2     = src2[5:0];
        u.src2_rdy = rdy2[0];
        u.imm      = {7'h20, rob[4:0]};
        return u;
    endfunction

    // an issued uop has both sources ready by definition
    function automatic lsu_iq_pkg::lsu_uop_t expected_uop(input logic [7:0] rob, input logic [7:0] op);
        lsu_iq_pkg::lsu_uop_t u;
        u          = sent[rob[4:0]];
        u.op       = lsu_iq_pkg::lsu_op_e'(op[2:0]);
        u.src1_rdy = 1'b1;
        u.src2_rdy = 1'b1;
        return u;
    endfunction

    task automatic cmp_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
            bit_errs++;
        end
    endtask

    task automatic cmp_op(input string name, input lsu_iq_pkg::lsu_uop_t exp,
            input lsu_iq_pkg::lsu_uop_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected rob %0d %s (%h), actual rob %0d %s (%h)",
                     name, exp.rob, exp.op.name(), exp, act.rob, act.op.name(), act);
            op_errs++;
        end
    endtask

    task automatic apply_row(input int k);
        for (int i = 0; i < 28; i++) begin
            row[i] = vec_mem[k*28 + i];
        end
        flush      = row[0][0];
        enq_req_0  = row[1][0];
        enq_uop_0  = make_uop(row[2], row[3], row[4], row[5], row[6], row[7]);
        enq_req_1  = row[8][0];
        enq_uop_1  = make_uop(row[9], row[10], row[11], row[12], row[13], row[14]);
        wake_en    = row[15][3:0];
        wake_tag_0 = row[16][5:0];
        wake_tag_1 = row[17][5:0];
        wake_tag_2 = row[18][5:0];
        wake_tag_3 = row[19][5:0];
        lsu_busy   = row[20][0];
        if (enq_req_0) sent[row[3][4:0]] = enq_uop_0;
        if (enq_req_1) sent[row[10][4:0]] = enq_uop_1;
    endtask

    task automatic check_row(input int k);
        string tag;
        tag = $sformatf("cycle %0d", k);
        cmp_bit({tag, " ready"}, row[21][0], ready);
        cmp_bit({tag, " issue_en_0"}, row[22][0], issue_en_0);
        if (row[22][0]) cmp_op({tag, " issue_uop_0"}, expected_uop(row[23], row[24]), issue_uop_0);
        cmp_bit({tag, " issue_en_1"}, row[25][0], issue_en_1);
        if (row[25][0]) cmp_op({tag, " issue_uop_1"}, expected_uop(row[26], row[27]), issue_uop_1);
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        wait (cycle_cnt >= cycle_limit);
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        int short_row;
        rst = 1'b1;
        flush = 1'b0;
        enq_req_0 = 1'b0;
        enq_req_1 = 1'b0;
        enq_uop_0 = '0;
        enq_uop_1 = '0;
        wake_en = '0;
        wake_tag_0 = '0;
        wake_tag_1 = '0;
        wake_tag_2 = '0;
        wake_tag_3 = '0;
        lsu_busy = 1'b0;
        short_row = 0;
        for (int i = 0; i < 1792; i++) vec_mem[i] = 8'hff;  // ff marks no data
        $readmemh("testbench/lsu_issue_input.txt", vec_mem);
        while (n_vec < 64 && vec_mem[n_vec*28] != 8'hff) begin
            if (vec_mem[n_vec*28 + 27] == 8'hff) short_row = 1;
            n_vec++;
        end
        if (n_vec == 0 || short_row != 0) begin
            if (n_vec == 0) $display("data file is missing or holds no vectors");
            else $display("data file ends in the middle of a row");
            $display("=== FAIL ===");
        end else begin
            cycle_limit = n_vec + 8 + 20;
            repeat (8) @(posedge clk);
            #10;
            rst = 1'b0;
            for (int k = 0; k < n_vec; k++) begin
                apply_row(k);
                #80;  // just before the next edge
                check_row(k);
                @(posedge clk);
                #10;
            end
            $display("checks done: %0d bit errors, %0d payload errors", bit_errs, op_errs);
            if (bit_errs + op_errs == 0) $display("=== PASS ===");
            else $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/lsu_iq_pkg.sv
hw/lsu_iq_entry.sv
hw/lsu_issue_queue.sv
hw/lsu_issue_arbiter.sv
hw/lsu_issue_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_lsu_issue_unit.sv

//--- Bender.yml
package:
  name: lsu_issue_unit

sources:
  - files:
      - hw/lsu_iq_pkg.sv
      - hw/lsu_iq_entry.sv
      - hw/lsu_issue_queue.sv
      - hw/lsu_issue_arbiter.sv
      - hw/lsu_issue_unit.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_lsu_issue_unit.sv

//--- testbench/lsu_issue_input.txt
// fl | req op rob src1 rdy1 src2 rdy2 (port 0, port 1) | wake_en tag0..3 | busy
// then expected: ready | issue_en_0 rob op | issue_en_1 rob op
0  1 2 01 0a 1 00 1  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 01 2 0 00 0
0  1 2 02 0b 0 00 1  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  1 0b 00 00 00  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 02 2 0 00 0
0  1 7 03 0c 0 0d 0  0 0 00 00 0 00 0  c 00 00 0c 0d  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 03 7 0 00 0
0  1 0 04 01 1 00 1  1 1 05 02 1 00 1  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 2 06 03 1 00 1  0 0 00 00 0 00 0  0 00 00 00 00  1  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 04 0 1 05 1
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 06 2 0 00 0
0  1 7 07 04 1 05 1  1 5 08 06 1 07 1  0 00 00 00 00  1  1 0 00 0 0 00 0
0  1 2 09 08 1 00 1  1 4 0a 09 1 00 1  0 00 00 00 00  1  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 07 7 1 09 2
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 08 5 1 0a 4
0  1 2 0b 20 0 00 1  1 1 0c 20 0 00 1  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 3 0d 20 0 00 1  1 4 0e 20 0 00 1  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 0 0f 20 0 00 1  1 2 10 20 0 00 1  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 1 11 20 0 00 1  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 2 12 20 0 00 1  1 2 13 20 0 00 1  0 00 00 00 00  0  0 0 00 0 0 00 0
0  1 0 14 20 1 00 1  0 0 00 00 0 00 0  2 00 20 00 00  0  0 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  0 1 0b 2 1 0c 1
0  1 0 15 21 1 00 1  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 0d 3 1 0e 4
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 0f 0 1 10 2
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 11 1 1 15 0
0  1 2 16 30 0 00 1  1 5 17 31 0 32 1  0 00 00 00 00  0  1 0 00 0 0 00 0
1  0 0 00 00 0 00 0  0 0 00 00 0 00 0  3 30 31 00 00  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
0  1 6 18 33 1 34 1  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 1 18 6 0 00 0
0  0 0 00 00 0 00 0  0 0 00 00 0 00 0  0 00 00 00 00  0  1 0 00 0 0 00 0
